// ==== design/ntt_pkg.sv ====
`default_nettype none
//----------------------------------------------------------
// ML-DSA NTT butterfly definitions
// Modulus, coefficient width, mode encoding and latencies
//----------------------------------------------------------

package ntt_pkg;

    //----------------------------------------------------------
    // Arithmetic
    //----------------------------------------------------------

    // Coefficient width, smallest that holds q-1
    localparam int COEFF_W = 23;

    // ML-DSA prime, q = 2^23 - 2^13 + 1
    localparam logic [COEFF_W-1:0] Q = 23'd8380417;

    //----------------------------------------------------------
    // Structure and timing
    //----------------------------------------------------------

    // Four lanes, two per layer in the 2x2 arrangement
    localparam int NUM_LANES = 4;

    // One lane: multiply-reduce step, then add/sub step
    localparam int BF_LATENCY = 2;

    // Layer 1 feeds layer 2 directly
    localparam int LAYER2_LATENCY = 2 * BF_LATENCY;

    // Operation mode
    // ct/gs use the lanes as two layers, the rest run lanes in parallel
    typedef enum logic [2:0] {
        ct  = 3'd0,   // Forward NTT, Cooley-Tukey
        gs  = 3'd1,   // Inverse NTT, Gentleman-Sande
        pwm = 3'd2,   // Pointwise multiply
        pwa = 3'd3,   // Pointwise add
        pws = 3'd4    // Pointwise subtract
    } mode_t;

endpackage

`default_nettype wire

// ==== design/ntt_bf_lane_if.sv ====
`timescale 1ns/10ps
`default_nettype none
//----------------------------------------------------------
// Butterfly lane bundle
// Operands into one lane and the two results out of it
//----------------------------------------------------------

interface ntt_bf_lane_if;

    // Operands, all reduced below q
    logic [ntt_pkg::COEFF_W-1:0] opu;
    logic [ntt_pkg::COEFF_W-1:0] opv;
    logic [ntt_pkg::COEFF_W-1:0] opw;

    // Results, two cycles after the operands
    logic [ntt_pkg::COEFF_W-1:0] res_u;
    logic [ntt_pkg::COEFF_W-1:0] res_v;

    // Operand router, also taps layer-1 results
    modport feed (
        output opu, opv, opw,
        input  res_u, res_v
    );

    // Butterfly lane itself
    modport lane (
        input  opu, opv, opw,
        output res_u, res_v
    );

    // Result collector
    modport drain (
        input res_u, res_v
    );

endinterface

`default_nettype wire

// ==== design/ntt_butterfly.sv ====
`timescale 1ns/10ps
`default_nettype none
//----------------------------------------------------------
// Modular butterfly lane, mod q = 8380417
// Two registered steps, covers ct, gs and pointwise modes
//----------------------------------------------------------

module ntt_butterfly (
    input  wire                 clk,
    input  wire                 reset_n,
    input  wire                 zeroize_i,
    input  wire ntt_pkg::mode_t mode_i,
    ntt_bf_lane_if.lane         lane
);

    localparam int W = ntt_pkg::COEFF_W;

    // 2^23 mod q = 2^13 - 1, folds the bits above W back in
    localparam logic [13:0] FOLD = 14'((1 << W) - ntt_pkg::Q);

    //----------------------------------------------------------
    // Modular helpers, inputs below q
    //----------------------------------------------------------
    function automatic logic [W-1:0] mod_add(input logic [W-1:0] a, input logic [W-1:0] b);
        logic [W:0] s;
        s = a + b;
        if (s >= {1'b0, ntt_pkg::Q})
            s = s - {1'b0, ntt_pkg::Q};
        return s[W-1:0];
    endfunction

    function automatic logic [W-1:0] mod_sub(input logic [W-1:0] a, input logic [W-1:0] b);
        logic [W:0] d;
        d = {1'b0, a} - {1'b0, b};
        // Borrow wraps, adding q lands back in range
        if (a < b)
            d = d + {1'b0, ntt_pkg::Q};
        return d[W-1:0];
    endfunction

    function automatic logic [W-1:0] mod_mul(input logic [W-1:0] a, input logic [W-1:0] b);
        logic [2*W-1:0] prod;
        logic [36:0]    t1;
        logic [27:0]    t2;
        logic [23:0]    t3;
        prod = a * b;
        // Three folds shrink 46 bits to below 2q
        t1 = prod[2*W-1:W] * FOLD + prod[W-1:0];
        t2 = t1[36:W] * FOLD + t1[W-1:0];
        t3 = t2[27:W] * FOLD + t2[W-1:0];
        if (t3 >= {1'b0, ntt_pkg::Q})
            t3 = t3 - {1'b0, ntt_pkg::Q};
        return t3[W-1:0];
    endfunction

    //----------------------------------------------------------
    // Step 1, multiply-reduce (gs forms u+v and u-v instead)
    //----------------------------------------------------------
    logic [W-1:0] mul_x, mul_y;
    logic [W-1:0] a_d, b_d;
    logic [W-1:0] a_q, b_q, w_q;

    // One multiplier serves ct (v*w) and pwm (u*v)
    assign mul_x = (mode_i == ntt_pkg::pwm) ? lane.opu : lane.opv;
    assign mul_y = (mode_i == ntt_pkg::pwm) ? lane.opv : lane.opw;

    always_comb begin
        a_d = lane.opu;
        b_d = '0;
        case (mode_i)
            ntt_pkg::ct: b_d = mod_mul(mul_x, mul_y);
            ntt_pkg::gs: begin
                a_d = mod_add(lane.opu, lane.opv);
                b_d = mod_sub(lane.opu, lane.opv);
            end
            ntt_pkg::pwm: a_d = mod_mul(mul_x, mul_y);
            ntt_pkg::pwa: a_d = mod_add(lane.opu, lane.opv);
            ntt_pkg::pws: a_d = mod_sub(lane.opu, lane.opv);
            default:      a_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a_q <= '0;
            b_q <= '0;
            w_q <= '0;
        end else if (zeroize_i) begin
            a_q <= '0;
            b_q <= '0;
            w_q <= '0;
        end else begin
            a_q <= a_d;
            b_q <= b_d;
            // Twiddle kept for the gs multiply in step 2
            w_q <= lane.opw;
        end
    end

    //----------------------------------------------------------
    // Step 2, add/sub (gs multiplies the difference here)
    //----------------------------------------------------------
    logic [W-1:0] res_u_d, res_v_d;
    logic [W-1:0] res_u_q, res_v_q;

    always_comb begin
        res_u_d = a_q;
        res_v_d = '0;
        if (mode_i == ntt_pkg::ct) begin
            res_u_d = mod_add(a_q, b_q);
            res_v_d = mod_sub(a_q, b_q);
        end else if (mode_i == ntt_pkg::gs) begin
            res_v_d = mod_mul(b_q, w_q);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_u_q <= '0;
            res_v_q <= '0;
        end else if (zeroize_i) begin
            res_u_q <= '0;
            res_v_q <= '0;
        end else begin
            res_u_q <= res_u_d;
            res_v_q <= res_v_d;
        end
    end

    assign lane.res_u = res_u_q;
    assign lane.res_v = res_v_q;

endmodule

`default_nettype wire

// ==== design/ntt_operand_router.sv ====
`timescale 1ns/10ps
`default_nettype none
//----------------------------------------------------------
// Operand router for the 2x2 butterfly
// Feeds all four lanes, crosses layer-1 results into layer 2
//----------------------------------------------------------

module ntt_operand_router (
    input  wire                                                clk,
    input  wire                                                reset_n,
    input  wire                                                zeroize_i,
    input  wire ntt_pkg::mode_t                                mode_i,
    input  wire [ntt_pkg::NUM_LANES-1:0][ntt_pkg::COEFF_W-1:0] u_i,
    input  wire [ntt_pkg::NUM_LANES-1:0][ntt_pkg::COEFF_W-1:0] v_i,
    input  wire [ntt_pkg::NUM_LANES-1:0][ntt_pkg::COEFF_W-1:0] w_i,
    ntt_bf_lane_if.feed                                        lane0,
    ntt_bf_lane_if.feed                                        lane1,
    ntt_bf_lane_if.feed                                        lane2,
    ntt_bf_lane_if.feed                                        lane3
);

    localparam int W = ntt_pkg::COEFF_W;
    localparam int D = ntt_pkg::BF_LATENCY;

    logic two_layer;

    // Layer-2 twiddles, index D-1 is the oldest
    logic [D-1:0][W-1:0] w2_dly;
    logic [D-1:0][W-1:0] w3_dly;

    assign two_layer = (mode_i inside {ntt_pkg::ct, ntt_pkg::gs});

    //----------------------------------------------------------
    // Twiddle alignment with layer-1 results
    //----------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            w2_dly <= '0;
            w3_dly <= '0;
        end else if (zeroize_i) begin
            w2_dly <= '0;
            w3_dly <= '0;
        end else begin
            w2_dly <= {w2_dly[D-2:0], w_i[2]};
            w3_dly <= {w3_dly[D-2:0], w_i[3]};
        end
    end

    //----------------------------------------------------------
    // Layer 1 lanes, always straight from the inputs
    //----------------------------------------------------------
    assign lane0.opu = u_i[0];
    assign lane0.opv = v_i[0];
    assign lane0.opw = w_i[0];

    assign lane1.opu = u_i[1];
    assign lane1.opv = v_i[1];
    assign lane1.opw = w_i[1];

    //----------------------------------------------------------
    // Layer 2 lanes
    //----------------------------------------------------------
    // Two-layer: lane 2 gets both u results, lane 3 both v results
    // Pointwise: plain inputs, twiddle unused but passed anyway
    always_comb begin
        if (two_layer) begin
            lane2.opu = lane0.res_u;
            lane2.opv = lane1.res_u;
            lane2.opw = w2_dly[D-1];
            lane3.opu = lane0.res_v;
            lane3.opv = lane1.res_v;
            lane3.opw = w3_dly[D-1];
        end else begin
            lane2.opu = u_i[2];
            lane2.opv = v_i[2];
            lane2.opw = w_i[2];
            lane3.opu = u_i[3];
            lane3.opv = v_i[3];
            lane3.opw = w_i[3];
        end
    end

endmodule

`default_nettype wire

// ==== design/ntt_result_collect.sv ====
`timescale 1ns/10ps
`default_nettype none
//----------------------------------------------------------
// Result collector for the 2x2 butterfly
// Maps lane results onto uv_o and times ready_o
//----------------------------------------------------------

module ntt_result_collect (
    input  wire                                                 clk,
    input  wire                                                 reset_n,
    input  wire                                                 zeroize_i,
    input  wire                                                 enable_i,
    input  wire ntt_pkg::mode_t                                 mode_i,
    ntt_bf_lane_if.drain                                        lane0,
    ntt_bf_lane_if.drain                                        lane1,
    ntt_bf_lane_if.drain                                        lane2,
    ntt_bf_lane_if.drain                                        lane3,
    output logic [ntt_pkg::NUM_LANES-1:0][ntt_pkg::COEFF_W-1:0] uv_o,
    output logic                                                ready_o
);

    logic two_layer;

    // Bit k holds enable from k+1 cycles back
    logic [ntt_pkg::LAYER2_LATENCY-1:0] en_dly;

    assign two_layer = (mode_i inside {ntt_pkg::ct, ntt_pkg::gs});

    //----------------------------------------------------------
    // Enable delay line
    //----------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            en_dly <= '0;
        end else if (zeroize_i) begin
            // Drops every pending ready pulse
            en_dly <= '0;
        end else begin
            en_dly <= {en_dly[ntt_pkg::LAYER2_LATENCY-2:0], enable_i};
        end
    end

    // Tap 4 for two layers, tap 2 for a single lane pass
    assign ready_o = two_layer ? en_dly[ntt_pkg::LAYER2_LATENCY-1]
                               : en_dly[ntt_pkg::BF_LATENCY-1];

    //----------------------------------------------------------
    // Output words
    //----------------------------------------------------------
    // Two-layer packs lane2.res_u in uv_o[3] down to lane3.res_v in uv_o[0]
    always_comb begin
        if (two_layer) begin
            uv_o = {lane2.res_u, lane2.res_v, lane3.res_u, lane3.res_v};
        end else begin
            uv_o[0] = lane0.res_u;
            uv_o[1] = lane1.res_u;
            uv_o[2] = lane2.res_u;
            uv_o[3] = lane3.res_u;
        end
    end

endmodule

`default_nettype wire

// ==== design/ntt_butterfly_2x2.sv ====
`timescale 1ns/10ps
`default_nettype none
//----------------------------------------------------------
// ML-DSA 2x2 NTT butterfly, unmasked
// Router, four modular lanes and the result collector
//----------------------------------------------------------

module ntt_butterfly_2x2 (
    input  wire                                                 clk,
    input  wire                                                 reset_n,
    input  wire                                                 zeroize_i,
    input  wire                                                 enable_i,
    input  wire ntt_pkg::mode_t                                 mode_i,
    input  wire [ntt_pkg::NUM_LANES-1:0][ntt_pkg::COEFF_W-1:0]  u_i,
    input  wire [ntt_pkg::NUM_LANES-1:0][ntt_pkg::COEFF_W-1:0]  v_i,
    input  wire [ntt_pkg::NUM_LANES-1:0][ntt_pkg::COEFF_W-1:0]  w_i,
    output logic [ntt_pkg::NUM_LANES-1:0][ntt_pkg::COEFF_W-1:0] uv_o,
    output logic                                                ready_o
);

    // One bundle per lane, 0/1 are layer 1 and 2/3 layer 2
    ntt_bf_lane_if lane_if [ntt_pkg::NUM_LANES] ();

    //----------------------------------------------------------
    // Operand routing
    //----------------------------------------------------------
    ntt_operand_router i_router (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_i),
        .u_i       (u_i),
        .v_i       (v_i),
        .w_i       (w_i),
        .lane0     (lane_if[0]),
        .lane1     (lane_if[1]),
        .lane2     (lane_if[2]),
        .lane3     (lane_if[3])
    );

    //----------------------------------------------------------
    // Butterfly lanes
    //----------------------------------------------------------
    for (genvar g = 0; g < ntt_pkg::NUM_LANES; g++) begin : g_lane
        ntt_butterfly i_bf (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .mode_i    (mode_i),
            .lane      (lane_if[g])
        );
    end

    //----------------------------------------------------------
    // Results and ready
    //----------------------------------------------------------
    ntt_result_collect i_collect (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .enable_i  (enable_i),
        .mode_i    (mode_i),
        .lane0     (lane_if[0]),
        .lane1     (lane_if[1]),
        .lane2     (lane_if[2]),
        .lane3     (lane_if[3]),
        .uv_o      (uv_o),
        .ready_o   (ready_o)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none
//----------------------------------------------------------
// Testbench clock and reset
// 8 ns clock, reset held low for the first 2 cycles
//----------------------------------------------------------

module tb_clock_gen (
    output logic clk_o,
    output logic reset_n_o
);

    // Half period of 4 ns
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // Release on a rising edge, like any other input
    initial begin
        reset_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        reset_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/ntt_butterfly_2x2_checker.sv ====
`timescale 1ns/10ps
`default_nettype none
//----------------------------------------------------------
// Assertions on the 2x2 butterfly outputs
// Ready timing against enable, result words below q
//----------------------------------------------------------

module ntt_butterfly_2x2_checker (
    input wire                                                clk,
    input wire                                                reset_n,
    input wire                                                zeroize_i,
    input wire                                                enable_i,
    input wire ntt_pkg::mode_t                                mode_i,
    input wire [ntt_pkg::NUM_LANES-1:0][ntt_pkg::COEFF_W-1:0] uv_o,
    input wire                                                ready_o
);

    // Count of failed assertions, summed into the final verdict
    int unsigned fail_cnt = 0;

    logic       two_layer;
    logic       uv_in_range;

    // Bit 0 is zeroize from one cycle back
    logic [3:0] zero_hist;

    assign two_layer   = (mode_i inside {ntt_pkg::ct, ntt_pkg::gs});
    assign uv_in_range = (uv_o[0] < ntt_pkg::Q) && (uv_o[1] < ntt_pkg::Q)
                      && (uv_o[2] < ntt_pkg::Q) && (uv_o[3] < ntt_pkg::Q);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            zero_hist <= '0;
        end else begin
            zero_hist <= {zero_hist[2:0], zeroize_i};
        end
    end

    //----------------------------------------------------------
    // Properties
    //----------------------------------------------------------
    // No ready while reset is held
    a_reset_quiet: assert property (@(posedge clk) !reset_n |-> !ready_o)
        else begin
            $error("ready_o high while reset is held");
            fail_cnt = fail_cnt + 1;
        end

    // Two layers, enable 4 cycles back and no zeroize since
    a_ready_two_layer: assert property (@(posedge clk) disable iff (!reset_n)
        (ready_o && two_layer) |->
            ($past(enable_i, ntt_pkg::LAYER2_LATENCY) && !(|zero_hist)))
        else begin
            $error("ready_o without a matching enable 4 cycles earlier");
            fail_cnt = fail_cnt + 1;
        end

    // Pointwise, enable 2 cycles back
    a_ready_pointwise: assert property (@(posedge clk) disable iff (!reset_n)
        (ready_o && !two_layer) |->
            ($past(enable_i, ntt_pkg::BF_LATENCY) && !(|zero_hist[1:0])))
        else begin
            $error("ready_o without a matching enable 2 cycles earlier");
            fail_cnt = fail_cnt + 1;
        end

    a_uv_below_q: assert property (@(posedge clk) disable iff (!reset_n)
        ready_o |-> uv_in_range)
        else begin
            $error("uv_o word not reduced below q");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind ntt_butterfly_2x2 ntt_butterfly_2x2_checker i_checker (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize_i (zeroize_i),
    .enable_i  (enable_i),
    .mode_i    (mode_i),
    .uv_o      (uv_o),
    .ready_o   (ready_o)
);

`default_nettype wire

// ==== tests/ntt_butterfly_2x2_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
//----------------------------------------------------------
// Testbench for the 2x2 NTT butterfly
// Table of rows per mode, modular model, in-order scoreboard
//----------------------------------------------------------

module ntt_butterfly_2x2_tb;

    localparam int W = ntt_pkg::COEFF_W;
    localparam int L = ntt_pkg::NUM_LANES;

    // Each mode group starts with its corner rows
    localparam int NUM_MODES     = 5;
    localparam int NUM_CORNER    = 3;
    localparam int ROWS_PER_MODE = 8;
    localparam int NUM_ROWS      = NUM_MODES * ROWS_PER_MODE;
    localparam int ZERO_ROWS     = 4;
    localparam int IDLE_GAP      = ntt_pkg::LAYER2_LATENCY;
    localparam int RESET_WAIT    = 6;
    localparam int TIMEOUT_CYC   = (NUM_ROWS + ZERO_ROWS) * 6 + 50;
    localparam int unsigned SEED = 32'ha8b1_88cc;

    typedef logic [L-1:0][W-1:0] vec_t;

    logic           clk;
    logic           reset_n;
    logic           zeroize_i;
    logic           enable_i;
    ntt_pkg::mode_t mode_i;
    vec_t           u_i;
    vec_t           v_i;
    vec_t           w_i;
    vec_t           uv_o;
    logic           ready_o;

    // Stimulus table with expected column
    ntt_pkg::mode_t row_mode [NUM_ROWS];
    vec_t           row_u    [NUM_ROWS];
    vec_t           row_v    [NUM_ROWS];
    vec_t           row_w    [NUM_ROWS];
    vec_t           row_exp  [NUM_ROWS];
    ntt_pkg::mode_t mode_list [NUM_MODES] = '{ntt_pkg::ct, ntt_pkg::gs, ntt_pkg::pwm,
                                              ntt_pkg::pwa, ntt_pkg::pws};

    // Scoreboard, expected words and due cycles in issue order
    vec_t cur_exp;
    vec_t exp_q [$];
    int   due_q [$];
    int   cyc       = 0;
    int   run_cyc   = 0;
    int   err_cnt   = 0;
    int   check_cnt = 0;
    int   pulse_cnt = 0;
    int   test_cnt  = 0;

    tb_clock_gen i_clk_gen (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    ntt_butterfly_2x2 i_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .enable_i  (enable_i),
        .mode_i    (mode_i),
        .u_i       (u_i),
        .v_i       (v_i),
        .w_i       (w_i),
        .uv_o      (uv_o),
        .ready_o   (ready_o)
    );

    //----------------------------------------------------------
    // Reference model, plain arithmetic mod q
    //----------------------------------------------------------
    function automatic logic [W-1:0] add_q(input logic [W-1:0] a, input logic [W-1:0] b);
        longint s;
        s = (longint'(a) + longint'(b)) % longint'(ntt_pkg::Q);
        return W'(s);
    endfunction

    function automatic logic [W-1:0] sub_q(input logic [W-1:0] a, input logic [W-1:0] b);
        longint s;
        s = (longint'(a) - longint'(b) + longint'(ntt_pkg::Q)) % longint'(ntt_pkg::Q);
        return W'(s);
    endfunction

    function automatic logic [W-1:0] mul_q(input logic [W-1:0] a, input logic [W-1:0] b);
        longint s;
        s = (longint'(a) * longint'(b)) % longint'(ntt_pkg::Q);
        return W'(s);
    endfunction

    // One butterfly by mode
    function automatic void bf_model(input ntt_pkg::mode_t m, input logic [W-1:0] u, v, w,
                                     output logic [W-1:0] ru, rv);
        ru = '0;
        rv = '0;
        case (m)
            ntt_pkg::ct: begin
                ru = add_q(u, mul_q(v, w));
                rv = sub_q(u, mul_q(v, w));
            end
            ntt_pkg::gs: begin
                ru = add_q(u, v);
                rv = mul_q(sub_q(u, v), w);
            end
            ntt_pkg::pwm: ru = mul_q(u, v);
            ntt_pkg::pwa: ru = add_q(u, v);
            ntt_pkg::pws: ru = sub_q(u, v);
            default:      ru = '0;
        endcase
    endfunction

    function automatic vec_t expected_uv(input ntt_pkg::mode_t m, input vec_t u, v, w);
        vec_t         r;
        logic [W-1:0] x0u, x0v, x1u, x1v, spare;
        r = '0;
        if (m == ntt_pkg::ct || m == ntt_pkg::gs) begin
            bf_model(m, u[0], v[0], w[0], x0u, x0v);
            bf_model(m, u[1], v[1], w[1], x1u, x1v);
            // Second layer, u results pair up, v results pair up
            bf_model(m, x0u, x1u, w[2], r[3], r[2]);
            bf_model(m, x0v, x1v, w[3], r[1], r[0]);
        end else begin
            for (int k = 0; k < L; k++)
                bf_model(m, u[k], v[k], w[k], r[k], spare);
        end
        return r;
    endfunction

    // Corner rows mix 0, 1 and q-1 across lanes, the rest are random
    function automatic void fill_table();
        logic [W-1:0] cv [3];
        int           r;
        cv[0] = '0;
        cv[1] = W'(1);
        cv[2] = W'(ntt_pkg::Q - 1);
        for (int m = 0; m < NUM_MODES; m++) begin
            for (int i = 0; i < ROWS_PER_MODE; i++) begin
                r = m * ROWS_PER_MODE + i;
                row_mode[r] = mode_list[m];
                for (int k = 0; k < L; k++) begin
                    if (i < NUM_CORNER) begin
                        row_u[r][k] = cv[(i + k) % 3];
                        row_v[r][k] = cv[(i + 2 * k + 1) % 3];
                        row_w[r][k] = cv[(i + k + 2) % 3];
                    end else begin
                        row_u[r][k] = W'($urandom % ntt_pkg::Q);
                        row_v[r][k] = W'($urandom % ntt_pkg::Q);
                        row_w[r][k] = W'($urandom % ntt_pkg::Q);
                    end
                end
                row_exp[r] = expected_uv(row_mode[r], row_u[r], row_v[r], row_w[r]);
            end
        end
    endfunction

    //----------------------------------------------------------
    // Scoreboard, sampled mid-cycle
    //----------------------------------------------------------
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (!reset_n) begin
            if (ready_o) begin
                $display("ready_o went high while reset was held, at %0d ns", $time);
                err_cnt++;
            end
        end else begin
            while (due_q.size() > 0 && due_q[0] < cyc) begin
                $display("Missing ready pulse, result due at cycle %0d never came", due_q[0]);
                err_cnt++;
                void'(due_q.pop_front());
                void'(exp_q.pop_front());
            end
            if (ready_o) begin
                pulse_cnt++;
                check_cnt++;
                if (due_q.size() == 0) begin
                    $display("Extra ready pulse at cycle %0d with nothing pending", cyc);
                    err_cnt++;
                end else begin
                    if (due_q[0] != cyc) begin
                        $display("Ready pulse at cycle %0d came early, due at cycle %0d",
                                 cyc, due_q[0]);
                        err_cnt++;
                    end else if (uv_o !== exp_q[0]) begin
                        $display("error: %0d ns: uv_o = %h, expected %h", $time, uv_o, exp_q[0]);
                        err_cnt++;
                    end
                    void'(due_q.pop_front());
                    void'(exp_q.pop_front());
                end
            end
            // Zeroize drops pending work, an enable in the same cycle too
            if (zeroize_i) begin
                due_q.delete();
                exp_q.delete();
            end else if (enable_i) begin
                exp_q.push_back(cur_exp);
                if (mode_i == ntt_pkg::ct || mode_i == ntt_pkg::gs)
                    due_q.push_back(cyc + ntt_pkg::LAYER2_LATENCY);
                else
                    due_q.push_back(cyc + ntt_pkg::BF_LATENCY);
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        run_cyc <= run_cyc + 1;
        if (run_cyc >= TIMEOUT_CYC) begin
            $display("Timeout, run still going after %0d cycles", run_cyc);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    //----------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------
    task automatic drive_row(input int r);
        mode_i   <= row_mode[r];
        u_i      <= row_u[r];
        v_i      <= row_v[r];
        w_i      <= row_w[r];
        cur_exp  <= row_exp[r];
        enable_i <= 1'b1;
    endtask

    // Back-to-back enables, then an idle gap that drains the pipeline
    task automatic run_group(input int first, input int count);
        int pulses_before;
        pulses_before = pulse_cnt;
        for (int r = first; r < first + count; r++) begin
            drive_row(r);
            @(posedge clk);
        end
        enable_i <= 1'b0;
        repeat (IDLE_GAP) @(posedge clk);
        check_cnt++;
        if (pulse_cnt - pulses_before != count) begin
            $display("Ready pulse count wrong, %0d pulses for %0d enables",
                     pulse_cnt - pulses_before, count);
            err_cnt++;
        end
    endtask

    // Two ct enables cut off inside the latency, then normal work
    task automatic zeroize_check();
        int pulses_before;
        pulses_before = pulse_cnt;
        drive_row(0);
        @(posedge clk);
        drive_row(1);
        @(posedge clk);
        enable_i  <= 1'b0;
        zeroize_i <= 1'b1;
        @(posedge clk);
        zeroize_i <= 1'b0;
        repeat (ntt_pkg::LAYER2_LATENCY + 2) @(posedge clk);
        check_cnt++;
        if (pulse_cnt != pulses_before) begin
            $display("Zeroize left %0d ready pulses behind", pulse_cnt - pulses_before);
            err_cnt++;
        end
        run_group(0, 2);
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before)
            $display("test %-8s passed", name);
        else
            $display("test %-8s failed with %0d errors", name, err_cnt - errs_before);
    endtask

    initial begin
        int errs_before;
        zeroize_i = 1'b0;
        enable_i  = 1'b0;
        mode_i    = ntt_pkg::ct;
        u_i       = '0;
        v_i       = '0;
        w_i       = '0;
        cur_exp   = '0;
        void'($urandom(SEED));
        fill_table();

        // Reset, ready must stay low through it and after
        errs_before = err_cnt;
        repeat (RESET_WAIT) @(posedge clk);
        report_test("reset", errs_before);

        for (int m = 0; m < NUM_MODES; m++) begin
            errs_before = err_cnt;
            run_group(m * ROWS_PER_MODE, ROWS_PER_MODE);
            report_test(mode_list[m].name(), errs_before);
        end

        errs_before = err_cnt;
        zeroize_check();
        report_test("zeroize", errs_before);

        $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_cnt, check_cnt, err_cnt, i_dut.i_checker.fail_cnt);
        if (err_cnt == 0 && i_dut.i_checker.fail_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/ntt_pkg.sv
design/ntt_bf_lane_if.sv
design/ntt_butterfly.sv
design/ntt_operand_router.sv
design/ntt_result_collect.sv
design/ntt_butterfly_2x2.sv
tests/tb_clock_gen.sv
tests/ntt_butterfly_2x2_checker.sv
tests/ntt_butterfly_2x2_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the 2x2 NTT butterfly testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=ntt_butterfly_2x2_tb
LOG=sim.log

if ! verilator --binary --assert -Wno-fatal --top-module "$TOP" -f vlog.f -o "$TOP"; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if ! grep -q "PASS: all tests" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0
